/* Bender.yml */
package:
  name: draw_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/draw_cmd_pkg.sv
      - verilog/draw_fsm_pkg.sv
      - verilog/draw_line.sv
      - verilog/draw_rectangle.sv
      - verilog/draw_rectangle_fill.sv
      - verilog/draw_pixel_mux.sv
      - verilog/draw_engine.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/draw_checker.sv
      - testbench/tb_draw_engine.sv

/* testbench/draw_checker.sv */
// Scoreboard for the drawing engine testbench.
// Predicts the pixel stream of each issued command and compares it with the DUT pixel port.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module draw_checker
    import draw_cmd_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          cmd_load,      // command accepted at this edge
    input  wire draw_op_e                      op,
    input  wire logic signed [`DRAW_CORDW-1:0] x0,
    input  wire logic signed [`DRAW_CORDW-1:0] y0,
    input  wire logic signed [`DRAW_CORDW-1:0] x1,
    input  wire logic signed [`DRAW_CORDW-1:0] y1,
    input  wire logic        [`DRAW_COLRW-1:0] colour,
    input  wire logic                          oe,
    input  wire logic signed [`DRAW_CORDW-1:0] x,             // DUT pixel port
    input  wire logic signed [`DRAW_CORDW-1:0] y,
    input  wire logic        [`DRAW_COLRW-1:0] pixel_colour,
    input  wire logic                          pixel_we,
    input  wire logic                          busy,
    input  wire logic                          done,
    output int                                 errors,
    output int                                 cmds_done,
    output int                                 pixels_seen
);

    int                     exp_x[$];     // predicted pixels, oldest first
    int                     exp_y[$];
    logic [`DRAW_COLRW-1:0] exp_colour;
    draw_op_e               exp_op;
    logic                   active;       // command between load and done
    int                     cmd_pixels;
    int                     cmd_errors;
    int                     ex;
    int                     ey;

    initial begin
        errors      = 0;
        cmds_done   = 0;
        pixels_seen = 0;
        active      = 1'b0;
    end

    task automatic report_failure(input string msg);
        $display("t=%0t %s", $time, msg);
        errors++;
        cmd_errors++;
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
            errors++;
            cmd_errors++;
        end
    endtask

    // straight edge, axis aligned, both ends included
    task automatic push_edge(input int xa, input int ya, input int xb, input int yb);
        int sx;
        int sy;
        int n;
        int i;
        sx = (xb > xa) ? 1 : ((xb < xa) ? -1 : 0);
        sy = (yb > ya) ? 1 : ((yb < ya) ? -1 : 0);
        n  = (xb - xa) * sx + (yb - ya) * sy;  // one term is always zero
        for (i = 0; i <= n; i++) begin
            exp_x.push_back(xa + sx * i);
            exp_y.push_back(ya + sy * i);
        end
    endtask

    // raster order, top row first, left to right
    task automatic push_fill(input int xa, input int ya, input int xb, input int yb);
        int xmin;
        int xmax;
        int ymin;
        int ymax;
        int xx;
        int yy;
        xmin = (xa < xb) ? xa : xb;
        xmax = (xa < xb) ? xb : xa;
        ymin = (ya < yb) ? ya : yb;
        ymax = (ya < yb) ? yb : ya;
        for (yy = ymin; yy <= ymax; yy++) begin
            for (xx = xmin; xx <= xmax; xx++) begin
                exp_x.push_back(xx);
                exp_y.push_back(yy);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (cmd_load) begin
                if (active)
                    report_failure("new command issued before the previous one finished");
                exp_x.delete();
                exp_y.delete();
                if (op == OP_FILL) begin
                    push_fill(x0, y0, x1, y1);
                end else begin  // four edges, corners appear twice
                    push_edge(x0, y0, x1, y0);
                    push_edge(x1, y0, x1, y1);
                    push_edge(x1, y1, x0, y1);
                    push_edge(x0, y1, x0, y0);
                end
                exp_colour = colour;
                exp_op     = op;
                active     = 1'b1;
                cmd_pixels = 0;
                cmd_errors = 0;
            end else if (!active && busy) begin
                report_failure("busy is high with no command running");
            end else if (active && !busy) begin
                report_failure("busy is low while a command is still running");
            end

            if (pixel_we) begin
                if (!oe)
                    report_failure("pixel_we is high while oe is low");
                if (!active || exp_x.size() == 0) begin
                    report_failure("pixel_we with no pixel left in the prediction");
                end else begin
                    ex = exp_x.pop_front();
                    ey = exp_y.pop_front();
                    check_value("x", x, ex);
                    check_value("y", y, ey);
                    check_value("pixel_colour", pixel_colour, exp_colour);
                    cmd_pixels++;
                    pixels_seen++;
                end
            end

            if (done) begin
                if (!active) begin
                    report_failure("done pulse with no command running");  // second pulse
                end else begin
                    if (exp_x.size() != 0)
                        report_failure($sformatf("done with %0d pixels still missing",
                                                 exp_x.size()));
                    $display("cmd %0d %s: %0d pixels, %0d errors",
                             cmds_done, exp_op.name(), cmd_pixels, cmd_errors);
                    cmds_done++;
                    active = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_draw_engine.sv */
// Testbench for the drawing engine: clock, reset, command table and random oe stalls.
// The draw_checker instance predicts and compares every pixel.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module tb_draw_engine
    import draw_cmd_pkg::*;
();

    localparam int NUM_CMDS = 9;

    logic                          clk;
    logic                          rst;
    logic                          start;
    logic                          cmd_load;      // tells the checker a command went in
    draw_op_e                      op;
    logic signed [`DRAW_CORDW-1:0] x0;
    logic signed [`DRAW_CORDW-1:0] y0;
    logic signed [`DRAW_CORDW-1:0] x1;
    logic signed [`DRAW_CORDW-1:0] y1;
    logic        [`DRAW_COLRW-1:0] colour;
    logic                          oe;
    logic signed [`DRAW_CORDW-1:0] x;
    logic signed [`DRAW_CORDW-1:0] y;
    logic        [`DRAW_COLRW-1:0] pixel_colour;
    logic                          pixel_we;
    logic                          busy;
    logic                          done;
    int                            errors;
    int                            cmds_done;
    int                            pixels_seen;

    // command table; mode 0 oe high, 1 random oe, 2 oe high plus a start while busy
    draw_op_e    tab_op[NUM_CMDS];
    int          tab_x0[NUM_CMDS];
    int          tab_y0[NUM_CMDS];
    int          tab_x1[NUM_CMDS];
    int          tab_y1[NUM_CMDS];
    int          tab_col[NUM_CMDS];
    int          tab_mode[NUM_CMDS];

    int unsigned lcg_state;
    logic        oe_random;
    int          cycles;
    int          cycle_limit;
    int          pixel_total;

    draw_engine u_draw_engine (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .op           (op),
        .x0           (x0),
        .y0           (y0),
        .x1           (x1),
        .y1           (y1),
        .colour       (colour),
        .oe           (oe),
        .x            (x),
        .y            (y),
        .pixel_colour (pixel_colour),
        .pixel_we     (pixel_we),
        .busy         (busy),
        .done         (done)
    );

    draw_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .cmd_load     (cmd_load),
        .op           (op),
        .x0           (x0),
        .y0           (y0),
        .x1           (x1),
        .y1           (y1),
        .colour       (colour),
        .oe           (oe),
        .x            (x),
        .y            (y),
        .pixel_colour (pixel_colour),
        .pixel_we     (pixel_we),
        .busy         (busy),
        .done         (done),
        .errors       (errors),
        .cmds_done    (cmds_done),
        .pixels_seen  (pixels_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int abs_int(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // pixel count from the size formulas
    function automatic int pixel_count(input int i);
        int w;
        int h;
        w = abs_int(tab_x1[i] - tab_x0[i]) + 1;
        h = abs_int(tab_y1[i] - tab_y0[i]) + 1;
        return (tab_op[i] == OP_FILL) ? w * h : 2 * w + 2 * h;
    endfunction

    task automatic set_entry(input int i, input draw_op_e o, input int ax, input int ay,
                             input int bx, input int by, input int col, input int mode);
        tab_op[i]   = o;
        tab_x0[i]   = ax;
        tab_y0[i]   = ay;
        tab_x1[i]   = bx;
        tab_y1[i]   = by;
        tab_col[i]  = col;
        tab_mode[i] = mode;
    endtask

    // oe changes 2 ns after the edge, like every other input
    always @(posedge clk) begin
        #2;
        if (oe_random) begin
            lcg_state = lcg_next(lcg_state);
            oe        = lcg_state[16];
        end else begin
            oe = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT never finished its commands", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic run_cmd(input int i);
        oe_random = (tab_mode[i] == 1);
        @(posedge clk);
        #2;
        op       = tab_op[i];
        x0       = tab_x0[i];
        y0       = tab_y0[i];
        x1       = tab_x1[i];
        y1       = tab_y1[i];
        colour   = tab_col[i];
        start    = 1'b1;
        cmd_load = 1'b1;
        @(posedge clk);
        #2;
        start    = 1'b0;
        cmd_load = 1'b0;
        if (tab_mode[i] == 2) begin  // other opcode and colour, must be dropped
            repeat (3) @(posedge clk);
            #2;
            op     = (tab_op[i] == OP_RECT) ? OP_FILL : OP_RECT;
            colour = ~colour;
            start  = 1'b1;
            @(posedge clk);
            #2;
            start  = 1'b0;
            op     = tab_op[i];
            colour = tab_col[i];
        end
        do @(posedge clk); while (done !== 1'b1);
        oe_random = 1'b0;
        repeat (2) @(posedge clk);  // idle gap, checker flags stray pixels
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        cmd_load    = 1'b0;
        op          = OP_RECT;
        x0          = '0;
        y0          = '0;
        x1          = '0;
        y1          = '0;
        colour      = '0;
        oe          = 1'b1;
        oe_random   = 1'b0;
        lcg_state   = 48;
        cycles      = 0;
        pixel_total = 0;

        set_entry(0, OP_RECT,  2,  3,  6,  5, 8'h1f, 0);  // plain outline
        set_entry(1, OP_FILL,  7,  6,  3,  4, 8'h2a, 0);  // swapped corners
        set_entry(2, OP_RECT, -3, -2,  4,  3, 8'h55, 1);  // stalls, negative coords
        set_entry(3, OP_FILL, -2,  5,  3,  1, 8'h66, 1);
        set_entry(4, OP_RECT,  1,  1,  5,  4, 8'h77, 2);  // start while busy
        set_entry(5, OP_FILL,  0,  0,  3,  2, 8'h88, 2);
        set_entry(6, OP_RECT, -5, -5, -5, -5, 8'h99, 0);  // single point
        set_entry(7, OP_FILL, -4,  2, -4, -3, 8'haa, 1);  // zero width
        set_entry(8, OP_RECT, 10, -7, 10, -2, 8'hbb, 1);

        for (int i = 0; i < NUM_CMDS; i++)
            pixel_total += pixel_count(i);
        cycle_limit = pixel_total * 4 + 200;

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < NUM_CMDS; i++)
            run_cmd(i);

        $display("commands %0d of %0d, pixels %0d of %0d, errors %0d",
                 cmds_done, NUM_CMDS, pixels_seen, pixel_total, errors);
        if (errors == 0 && cmds_done == NUM_CMDS && pixels_seen == pixel_total) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/draw_cmd_pkg.sv */
// Command encodings for the drawing engine.
// Import into any block that decodes or issues a drawing opcode.
`default_nettype none

package draw_cmd_pkg;

    // one opcode per drawer
    typedef enum logic [0:0] {
        OP_RECT = 1'b0,  // rectangle outline
        OP_FILL = 1'b1   // filled rectangle
    } draw_op_e;

endpackage

`default_nettype wire

/* verilog/draw_defs.svh */
// Width macros shared by the drawing engine RTL and its testbench.
// Include wherever coordinate or colour buses are declared.
`ifndef DRAW_DEFS_SVH
`define DRAW_DEFS_SVH

// signed screen coordinate, wide enough for negative offsets
`define DRAW_CORDW 16

// colour word carried with every pixel write
`define DRAW_COLRW 8

`endif

/* verilog/draw_engine.sv */
// Top of the 2D drawing engine: command mux plus outline and fill drawers.
// Drive start with op, corners and colour; one pixel_we per emitted pixel.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module draw_engine
    import draw_cmd_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire draw_op_e                      op,
    input  wire logic signed [`DRAW_CORDW-1:0] x0,
    input  wire logic signed [`DRAW_CORDW-1:0] y0,
    input  wire logic signed [`DRAW_CORDW-1:0] x1,
    input  wire logic signed [`DRAW_CORDW-1:0] y1,
    input  wire logic        [`DRAW_COLRW-1:0] colour,
    input  wire logic                          oe,            // back-pressure level
    output      logic signed [`DRAW_CORDW-1:0] x,
    output      logic signed [`DRAW_CORDW-1:0] y,
    output      logic        [`DRAW_COLRW-1:0] pixel_colour,
    output      logic                          pixel_we,
    output      logic                          busy,
    output      logic                          done
);

    logic                          rect_start, fill_start;
    logic signed [`DRAW_CORDW-1:0] rect_x, rect_y;
    logic signed [`DRAW_CORDW-1:0] fill_x, fill_y;
    logic                          rect_drawing, rect_done;
    logic                          fill_drawing, fill_done;

    draw_pixel_mux u_mux (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .op           (op),
        .colour       (colour),
        .rect_x       (rect_x),
        .rect_y       (rect_y),
        .rect_drawing (rect_drawing),
        .rect_done    (rect_done),
        .fill_x       (fill_x),
        .fill_y       (fill_y),
        .fill_drawing (fill_drawing),
        .fill_done    (fill_done),
        .rect_start   (rect_start),
        .fill_start   (fill_start),
        .x            (x),
        .y            (y),
        .pixel_colour (pixel_colour),
        .pixel_we     (pixel_we),
        .busy         (busy),
        .done         (done)
    );

    draw_rectangle u_rect (
        .clk     (clk),
        .rst     (rst),
        .start   (rect_start),
        .oe      (oe),
        .x0      (x0),
        .y0      (y0),
        .x1      (x1),
        .y1      (y1),
        .x       (rect_x),
        .y       (rect_y),
        .drawing (rect_drawing),
        .done    (rect_done)
    );

    draw_rectangle_fill u_fill (
        .clk     (clk),
        .rst     (rst),
        .start   (fill_start),
        .oe      (oe),
        .x0      (x0),
        .y0      (y0),
        .x1      (x1),
        .y1      (y1),
        .x       (fill_x),
        .y       (fill_y),
        .drawing (fill_drawing),
        .done    (fill_done)
    );

endmodule

`default_nettype wire

/* verilog/draw_fsm_pkg.sv */
// State encodings for the line, outline and fill state machines.
// Each drawer imports this and uses its own enum.
`default_nettype none

package draw_fsm_pkg;

    // Bresenham line stepper
    typedef enum logic [1:0] {
        L_IDLE = 2'd0,  // waiting for start
        L_INIT = 2'd1,  // latch endpoints, set up error term
        L_DRAW = 2'd2   // one pixel per enabled clock
    } line_state_e;

    // outline sequencer
    typedef enum logic [1:0] {
        R_IDLE = 2'd0,
        R_INIT = 2'd1,  // pick edge endpoints
        R_DRAW = 2'd2   // wait for the edge to finish
    } rect_state_e;

    // raster fill
    typedef enum logic [1:0] {
        F_IDLE = 2'd0,
        F_INIT = 2'd1,  // sort corners
        F_DRAW = 2'd2
    } fill_state_e;

endpackage

`default_nettype wire

/* verilog/draw_line.sv */
// Bresenham line drawer, one pixel per clock while oe is high.
// Pulse start with the endpoints stable; done pulses after the last pixel.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module draw_line
    import draw_fsm_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,    // begin a new line
    input  wire logic                          oe,       // output enable, stalls when low
    input  wire logic signed [`DRAW_CORDW-1:0] x0,       // start point
    input  wire logic signed [`DRAW_CORDW-1:0] y0,
    input  wire logic signed [`DRAW_CORDW-1:0] x1,       // end point
    input  wire logic signed [`DRAW_CORDW-1:0] y1,
    output      logic signed [`DRAW_CORDW-1:0] x,        // current pixel
    output      logic signed [`DRAW_CORDW-1:0] y,
    output      logic                          drawing,  // pixel valid this cycle
    output      logic                          done      // one-cycle completion pulse
);

    line_state_e state;

    // one extra bit so differences of signed coords never overflow
    logic signed [`DRAW_CORDW:0]   x0e, y0e, x1e, y1e;
    logic signed [`DRAW_CORDW:0]   dx_abs, dy_abs;  // setup values from inputs
    logic signed [`DRAW_CORDW:0]   dx, dy;          // dx positive, dy negated
    logic signed [`DRAW_CORDW:0]   err;
    logic signed [`DRAW_CORDW+1:0] e2;
    logic signed [`DRAW_CORDW-1:0] xend, yend;      // latched end point
    logic                          right, down;     // step directions
    logic                          movx, movy;

    assign x0e = x0;  // sign extend
    assign y0e = y0;
    assign x1e = x1;
    assign y1e = y1;

    always_comb begin
        dx_abs = (x1e > x0e) ? x1e - x0e : x0e - x1e;
        dy_abs = (y1e > y0e) ? y1e - y0e : y0e - y1e;
        e2     = $signed({err, 1'b0});  // 2 * err
        movx   = (e2 >= dy);
        movy   = (e2 <= dx);
    end

    always_ff @(posedge clk) begin
        done <= 1'b0;
        case (state)
            L_INIT: begin
                dx    <= dx_abs;
                dy    <= -dy_abs;
                err   <= dx_abs - dy_abs;
                right <= (x0 < x1);
                down  <= (y0 < y1);
                x     <= x0;
                y     <= y0;
                xend  <= x1;
                yend  <= y1;
                state <= L_DRAW;
            end
            L_DRAW: begin
                if (oe) begin
                    if (x == xend && y == yend) begin  // last pixel goes out now
                        state <= L_IDLE;
                        done  <= 1'b1;
                    end else begin
                        err <= err + (movx ? dy : '0) + (movy ? dx : '0);
                        if (movx) x <= right ? x + 1'b1 : x - 1'b1;
                        if (movy) y <= down ? y + 1'b1 : y - 1'b1;
                    end
                end
            end
            L_IDLE: begin
                if (start) state <= L_INIT;
            end
            default: state <= L_IDLE;
        endcase

        if (rst) begin
            state <= L_IDLE;
            done  <= 1'b0;
        end
    end

    assign drawing = (state == L_DRAW) && oe;

    // completion never overlaps a pixel write
    a_done_not_drawing: assert property (@(posedge clk) disable iff (rst)
        !(done && drawing))
        else $error("line done while drawing");

endmodule

`default_nettype wire

/* verilog/draw_pixel_mux.sv */
// Command dispatch and output merge for the two rectangle drawers.
// Accepts a start only when idle, then forwards the chosen drawer's pixels.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module draw_pixel_mux
    import draw_cmd_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,         // command strobe
    input  wire draw_op_e                      op,
    input  wire logic        [`DRAW_COLRW-1:0] colour,
    input  wire logic signed [`DRAW_CORDW-1:0] rect_x,        // outline drawer
    input  wire logic signed [`DRAW_CORDW-1:0] rect_y,
    input  wire logic                          rect_drawing,
    input  wire logic                          rect_done,
    input  wire logic signed [`DRAW_CORDW-1:0] fill_x,        // fill drawer
    input  wire logic signed [`DRAW_CORDW-1:0] fill_y,
    input  wire logic                          fill_drawing,
    input  wire logic                          fill_done,
    output      logic                          rect_start,
    output      logic                          fill_start,
    output      logic signed [`DRAW_CORDW-1:0] x,             // merged pixel port
    output      logic signed [`DRAW_CORDW-1:0] y,
    output      logic        [`DRAW_COLRW-1:0] pixel_colour,
    output      logic                          pixel_we,
    output      logic                          busy,
    output      logic                          done
);

    draw_op_e               op_r;      // opcode of the running command
    logic [`DRAW_COLRW-1:0] colour_r;

    always_ff @(posedge clk) begin
        rect_start <= 1'b0;
        fill_start <= 1'b0;
        if (!busy) begin
            if (start) begin  // starts while busy are dropped
                busy       <= 1'b1;
                op_r       <= op;
                colour_r   <= colour;
                rect_start <= (op == OP_RECT);
                fill_start <= (op == OP_FILL);
            end
        end else if (done) begin
            busy <= 1'b0;
        end

        if (rst) begin
            busy       <= 1'b0;
            op_r       <= OP_RECT;
            rect_start <= 1'b0;
            fill_start <= 1'b0;
        end
    end

    always_comb begin
        if (op_r == OP_FILL) begin
            x        = fill_x;
            y        = fill_y;
            pixel_we = fill_drawing;
            done     = busy && fill_done;
        end else begin
            x        = rect_x;
            y        = rect_y;
            pixel_we = rect_drawing;
            done     = busy && rect_done;
        end
    end

    assign pixel_colour = colour_r;

    // only one drawer may ever be active
    a_one_drawer: assert property (@(posedge clk) disable iff (rst)
        !(rect_drawing && fill_drawing))
        else $error("both drawers emitting pixels");

endmodule

`default_nettype wire

/* verilog/draw_rectangle.sv */
// Rectangle outline drawer; walks the four edges through one line drawer.
// Corners must stay stable from start until done.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module draw_rectangle
    import draw_fsm_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,    // begin outline
    input  wire logic                          oe,       // output enable
    input  wire logic signed [`DRAW_CORDW-1:0] x0,       // corner a
    input  wire logic signed [`DRAW_CORDW-1:0] y0,
    input  wire logic signed [`DRAW_CORDW-1:0] x1,       // opposite corner
    input  wire logic signed [`DRAW_CORDW-1:0] y1,
    output      logic signed [`DRAW_CORDW-1:0] x,        // current pixel
    output      logic signed [`DRAW_CORDW-1:0] y,
    output      logic                          drawing,  // pixel valid
    output      logic                          done      // outline finished
);

    rect_state_e state;

    logic [1:0]                    line_id;     // edge number 0..3
    logic                          line_start;  // kick the line drawer
    logic                          line_done;
    logic signed [`DRAW_CORDW-1:0] lx0, ly0;    // edge start
    logic signed [`DRAW_CORDW-1:0] lx1, ly1;    // edge end

    always_ff @(posedge clk) begin
        line_start <= 1'b0;
        done       <= 1'b0;
        case (state)
            R_INIT: begin
                // edges go clockwise from (x0,y0)
                case (line_id)
                    2'd0: begin
                        lx0 <= x0;
                        ly0 <= y0;
                        lx1 <= x1;
                        ly1 <= y0;
                    end
                    2'd1: begin
                        lx0 <= x1;
                        ly0 <= y0;
                        lx1 <= x1;
                        ly1 <= y1;
                    end
                    2'd2: begin
                        lx0 <= x1;
                        ly0 <= y1;
                        lx1 <= x0;
                        ly1 <= y1;
                    end
                    default: begin  // closing edge back to the origin
                        lx0 <= x0;
                        ly0 <= y1;
                        lx1 <= x0;
                        ly1 <= y0;
                    end
                endcase
                line_start <= 1'b1;
                state      <= R_DRAW;
            end
            R_DRAW: begin
                if (line_done) begin
                    if (line_id == 2'd3) begin
                        done  <= 1'b1;
                        state <= R_IDLE;
                    end else begin
                        line_id <= line_id + 2'd1;
                        state   <= R_INIT;
                    end
                end
            end
            R_IDLE: begin
                if (start) begin
                    line_id <= 2'd0;
                    state   <= R_INIT;
                end
            end
            default: state <= R_IDLE;
        endcase

        if (rst) begin
            state      <= R_IDLE;
            line_id    <= 2'd0;
            line_start <= 1'b0;
            done       <= 1'b0;
        end
    end

    draw_line u_line (
        .clk     (clk),
        .rst     (rst),
        .start   (line_start),
        .oe      (oe),
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (x),
        .y       (y),
        .drawing (drawing),
        .done    (line_done)
    );

    // next edge only starts once the previous one has stopped emitting
    a_start_idle_line: assert property (@(posedge clk) disable iff (rst)
        line_start |-> !drawing)
        else $error("edge restarted while line still drawing");

endmodule

`default_nettype wire

/* verilog/draw_rectangle_fill.sv */
// Filled rectangle drawer, raster order from the lowest corner.
// Corners may come in any order; hold them stable until the INIT cycle is past.
`default_nettype none
`timescale 1ns/1ps

`include "draw_defs.svh"

module draw_rectangle_fill
    import draw_fsm_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,    // begin fill
    input  wire logic                          oe,       // output enable
    input  wire logic signed [`DRAW_CORDW-1:0] x0,       // corner a
    input  wire logic signed [`DRAW_CORDW-1:0] y0,
    input  wire logic signed [`DRAW_CORDW-1:0] x1,       // corner b
    input  wire logic signed [`DRAW_CORDW-1:0] y1,
    output      logic signed [`DRAW_CORDW-1:0] x,        // current pixel
    output      logic signed [`DRAW_CORDW-1:0] y,
    output      logic                          drawing,
    output      logic                          done
);

    fill_state_e state;

    logic signed [`DRAW_CORDW-1:0] xlo, xhi, ylo, yhi;      // sorted inputs
    logic signed [`DRAW_CORDW-1:0] xmin, xmax, ymin, ymax;  // registered bounds

    always_comb begin
        xlo = (x0 < x1) ? x0 : x1;
        xhi = (x0 < x1) ? x1 : x0;
        ylo = (y0 < y1) ? y0 : y1;
        yhi = (y0 < y1) ? y1 : y0;
    end

    always_ff @(posedge clk) begin
        done <= 1'b0;
        case (state)
            F_INIT: begin
                xmin  <= xlo;
                xmax  <= xhi;
                ymin  <= ylo;
                ymax  <= yhi;
                x     <= xlo;  // top left first
                y     <= ylo;
                state <= F_DRAW;
            end
            F_DRAW: begin
                if (oe) begin
                    if (x == xmax) begin
                        if (y == ymax) begin  // bottom right emitted
                            state <= F_IDLE;
                            done  <= 1'b1;
                        end else begin
                            x <= xmin;  // wrap to next row
                            y <= y + 1'b1;
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end
            end
            F_IDLE: begin
                if (start) state <= F_INIT;
            end
            default: state <= F_IDLE;
        endcase

        if (rst) begin
            state <= F_IDLE;
            done  <= 1'b0;
        end
    end

    assign drawing = (state == F_DRAW) && oe;

    a_inside_bounds: assert property (@(posedge clk) disable iff (rst)
        drawing |-> (x >= xmin && x <= xmax && y >= ymin && y <= ymax))
        else $error("fill pixel outside rectangle");

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/draw_cmd_pkg.sv
verilog/draw_fsm_pkg.sv
verilog/draw_line.sv
verilog/draw_rectangle.sv
verilog/draw_rectangle_fill.sv
verilog/draw_pixel_mux.sv
verilog/draw_engine.sv
testbench/draw_checker.sv
testbench/tb_draw_engine.sv
